// File: rtl/cell_search_pkg.sv
package cell_search_pkg;

    localparam int SAMPLE_W = 8;
    localparam int CORR_W   = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [CORR_W-1:0]   corr_t;

    // PSS chips, bit n is chip n and a set bit means +1
    localparam int PSS_LEN   = 16;
    localparam int PSS_COUNT = 3;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_0 = 16'h7591;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_1 = 16'hC7AC;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_2 = 16'h323D;
    localparam logic [PSS_COUNT-1:0][PSS_LEN-1:0] PSS_SEQS = {
        PSS_SEQ_2,
        PSS_SEQ_1,
        PSS_SEQ_0
    };
    localparam int PSS_THRESHOLD = 480;
    localparam int PSS_FILL_W    = $clog2(PSS_LEN + 1);

    localparam int GAP_LEN = 16;
    localparam int SSS_LEN = 31;

    // m-sequence of x^5 + x^2 + 1, seed 00001, bit n is chip n
    localparam logic [SSS_LEN-1:0] SSS_MSEQ = 31'b010_1110_1100_0111_1100_1101_0010_0001;
    localparam int SSS_SHIFT_STEP = 5;
    localparam int N_ID1_COUNT    = 8;
    localparam int SYNC_CNT_W     = $clog2(SSS_LEN);

    typedef logic [1:0]                         n_id_2_t;
    typedef logic [$clog2(N_ID1_COUNT)-1:0]     n_id_1_t;
    typedef logic [4:0]                         n_id_t;
    typedef logic [SYNC_CNT_W-1:0]              sync_cnt_t;
    typedef logic [PSS_FILL_W-1:0]              pss_fill_t;

    typedef enum logic [1:0] {
        SYNC_SEARCH,
        SYNC_GAP,
        SYNC_SSS
    } sync_state_t;

endpackage

// File: rtl/pss_correlator.sv
`timescale 1ns/1ps

module pss_correlator (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cell_search_pkg::sample_t sample_i,
    input  logic                     sample_valid_i,
    input  logic                     search_i,
    output logic                     pss_hit_o,
    output cell_search_pkg::n_id_2_t n_id_2_o
);
    import cell_search_pkg::*;

    sample_t   win      [PSS_LEN];
    sample_t   win_next [PSS_LEN];
    pss_fill_t fill;
    logic      search_q;
    corr_t     sum      [PSS_COUNT];
    corr_t     best_sum;
    n_id_2_t   best_idx;
    logic      above;
    logic      hit_next;

    // Window as it looks once the incoming sample is shifted in
    always_comb begin
        for (int n = 0; n < PSS_LEN - 1; n++) begin
            win_next[n] = win[n + 1];
        end
        win_next[PSS_LEN - 1] = sample_i;
    end

    always_comb begin
        for (int s = 0; s < PSS_COUNT; s++) begin
            sum[s] = '0;
            for (int n = 0; n < PSS_LEN; n++) begin
                if (PSS_SEQS[s][n]) begin
                    sum[s] = sum[s] + corr_t'(win_next[n]);
                end else begin
                    sum[s] = sum[s] - corr_t'(win_next[n]);
                end
            end
        end
    end

    // Largest sum, lowest index on a tie
    always_comb begin
        best_sum = sum[0];
        best_idx = '0;
        for (int s = 1; s < PSS_COUNT; s++) begin
            if (sum[s] > best_sum) begin
                best_sum = sum[s];
                best_idx = n_id_2_t'(s);
            end
        end
        above = best_sum >= corr_t'(PSS_THRESHOLD);
    end

    assign hit_next = sample_valid_i && search_i && search_q && above &&
                      (fill >= pss_fill_t'(PSS_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fill      <= '0;
            search_q  <= 1'b1;
            pss_hit_o <= 1'b0;
        end else begin
            // Own view of search drops right after a hit
            search_q  <= search_i && !hit_next;
            pss_hit_o <= hit_next;
            if (!search_i) begin
                fill <= '0;
            end else if (sample_valid_i && fill != pss_fill_t'(PSS_LEN)) begin
                fill <= fill + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !search_i) begin
            for (int n = 0; n < PSS_LEN; n++) begin
                win[n] <= '0;
            end
        end else if (sample_valid_i) begin
            win <= win_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit_next) begin
            n_id_2_o <= best_idx;
        end
    end

endmodule

// File: rtl/frame_sync.sv
`timescale 1ns/1ps

module frame_sync (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cell_search_pkg::sample_t sample_i,
    input  logic                     sample_valid_i,
    input  logic                     pss_hit_i,
    input  cell_search_pkg::n_id_2_t n_id_2_i,
    output logic                     search_o,
    output cell_search_pkg::sample_t sss_sample_o,
    output logic                     sss_valid_o,
    output logic                     sss_last_o,
    output cell_search_pkg::n_id_2_t sss_n_id_2_o
);
    import cell_search_pkg::*;

    sync_state_t state;
    sync_cnt_t   cnt;

    // Search stops in the very cycle the hit is seen
    assign search_o = (state == SYNC_SEARCH) && !pss_hit_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state       <= SYNC_SEARCH;
            cnt         <= '0;
            sss_valid_o <= 1'b0;
            sss_last_o  <= 1'b0;
        end else begin
            sss_valid_o <= (state == SYNC_SSS) && sample_valid_i;
            sss_last_o  <= (state == SYNC_SSS) && sample_valid_i &&
                           (cnt == sync_cnt_t'(SSS_LEN - 1));
            case (state)
                SYNC_SEARCH: begin
                    if (pss_hit_i) begin
                        // A sample in the hit cycle is already part of the gap
                        cnt   <= sample_valid_i ? sync_cnt_t'(1) : '0;
                        state <= SYNC_GAP;
                    end
                end
                SYNC_GAP: begin
                    if (sample_valid_i) begin
                        if (cnt == sync_cnt_t'(GAP_LEN - 1)) begin
                            cnt   <= '0;
                            state <= SYNC_SSS;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                SYNC_SSS: begin
                    if (sample_valid_i) begin
                        if (cnt == sync_cnt_t'(SSS_LEN - 1)) begin
                            cnt   <= '0;
                            state <= SYNC_SEARCH;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= SYNC_SEARCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sss_sample_o <= sample_i;
        end
        if (state == SYNC_SEARCH && pss_hit_i) begin
            sss_n_id_2_o <= n_id_2_i;
        end
    end

endmodule

// File: rtl/sss_detector.sv
`timescale 1ns/1ps

module sss_detector (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cell_search_pkg::sample_t sss_sample_i,
    input  logic                     sss_valid_i,
    input  logic                     sss_last_i,
    input  cell_search_pkg::n_id_2_t n_id_2_i,
    output cell_search_pkg::n_id_1_t n_id_1_o,
    output cell_search_pkg::n_id_t   n_id_o,
    output logic                     n_id_valid_o
);
    import cell_search_pkg::*;

    sync_cnt_t idx;
    corr_t     acc  [N_ID1_COUNT];
    logic      chip [N_ID1_COUNT];
    logic      done_q;
    corr_t     best_val;
    n_id_1_t   best_k;
    n_id_t     n_id_next;

    // Chip of candidate k at the current sample index
    always_comb begin
        int pos;
        for (int k = 0; k < N_ID1_COUNT; k++) begin
            pos = (int'(idx) + SSS_SHIFT_STEP * k + int'(n_id_2_i)) % SSS_LEN;
            chip[k] = SSS_MSEQ[pos];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            idx    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= sss_valid_i && sss_last_i;
            if (sss_valid_i) begin
                idx <= sss_last_i ? '0 : idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || done_q) begin
            for (int k = 0; k < N_ID1_COUNT; k++) begin
                acc[k] <= '0;
            end
        end else if (sss_valid_i) begin
            for (int k = 0; k < N_ID1_COUNT; k++) begin
                if (chip[k]) begin
                    acc[k] <= acc[k] + corr_t'(sss_sample_i);
                end else begin
                    acc[k] <= acc[k] - corr_t'(sss_sample_i);
                end
            end
        end
    end

    // Arg-max over the candidates, lowest index wins a tie
    always_comb begin
        best_val = acc[0];
        best_k   = '0;
        for (int k = 1; k < N_ID1_COUNT; k++) begin
            if (acc[k] > best_val) begin
                best_val = acc[k];
                best_k   = n_id_1_t'(k);
            end
        end
        n_id_next = n_id_t'(best_k) * 5'd3 + n_id_t'(n_id_2_i);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            n_id_valid_o <= 1'b0;
        end else begin
            n_id_valid_o <= done_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_q) begin
            n_id_1_o <= best_k;
            n_id_o   <= n_id_next;
        end
    end

endmodule

// File: rtl/cell_search.sv
`timescale 1ns/1ps

module cell_search (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  cell_search_pkg::sample_t sample_i,
    input  logic                     sample_valid_i,
    output logic                     pss_hit_o,
    output cell_search_pkg::n_id_2_t n_id_2_o,
    output logic                     sss_valid_o,
    output cell_search_pkg::n_id_1_t n_id_1_o,
    output cell_search_pkg::n_id_t   n_id_o,
    output logic                     n_id_valid_o
);
    import cell_search_pkg::*;

    logic    search;
    sample_t sss_sample;
    logic    sss_last;
    n_id_2_t sss_n_id_2;

    pss_correlator pss_correlator0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .search_i       (search),
        .pss_hit_o      (pss_hit_o),
        .n_id_2_o       (n_id_2_o)
    );

    frame_sync frame_sync0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pss_hit_i      (pss_hit_o),
        .n_id_2_i       (n_id_2_o),
        .search_o       (search),
        .sss_sample_o   (sss_sample),
        .sss_valid_o    (sss_valid_o),
        .sss_last_o     (sss_last),
        .sss_n_id_2_o   (sss_n_id_2)
    );

    sss_detector sss_detector0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sss_sample_i   (sss_sample),
        .sss_valid_i    (sss_valid_o),
        .sss_last_i     (sss_last),
        .n_id_2_i       (sss_n_id_2),
        .n_id_1_o       (n_id_1_o),
        .n_id_o         (n_id_o),
        .n_id_valid_o   (n_id_valid_o)
    );

endmodule

// File: bench/cell_search_model.svh
// Chips are returned as +1 or -1, chip 0 is the oldest sample
function automatic int pss_chip(input int s, input int n);
    logic [PSS_LEN-1:0] seq;
    logic [PSS_LEN-1:0] bits;
    case (s)
        0: seq = PSS_SEQ_0;
        1: seq = PSS_SEQ_1;
        default: seq = PSS_SEQ_2;
    endcase
    bits = seq >> n;
    return bits[0] ? 1 : -1;
endfunction

// Candidate k reads the m-sequence cyclically shifted by 5k + n_id_2
function automatic int sss_chip(input int k, input int n, input int nid2);
    logic [SSS_LEN-1:0] bits;
    bits = SSS_MSEQ >> ((n + SSS_SHIFT_STEP * k + nid2) % SSS_LEN);
    return bits[0] ? 1 : -1;
endfunction

function automatic int pss_corr(input int s, input int win [PSS_LEN]);
    int sum;
    sum = 0;
    for (int n = 0; n < PSS_LEN; n++) begin
        sum += win[n] * pss_chip(s, n);
    end
    return sum;
endfunction

// Lowest index wins a tie
function automatic int arg_max(input int vals [N_ID1_COUNT], input int count);
    int best;
    best = 0;
    for (int i = 1; i < count; i++) begin
        if (vals[i] > vals[best]) begin
            best = i;
        end
    end
    return best;
endfunction

// File: bench/tb_cell_search.sv
`timescale 1ns/1ps

module tb_cell_search;
    import cell_search_pkg::*;

    localparam int BURSTS    = 20;
    localparam int MAX_CYC   = 8192;
    localparam int RESET_CYC = 16;
    localparam int QUIET_CYC = 50;
    localparam int TIMEOUT   = 500;

    `include "cell_search_model.svh"

    logic    clk;
    logic    reset;
    sample_t sample;
    logic    sample_valid;
    logic    pss_hit;
    n_id_2_t n_id_2;
    logic    sss_valid;
    n_id_1_t n_id_1;
    n_id_t   n_id;
    logic    n_id_valid;

    // Stimulus and expected pulses per clock cycle
    sample_t stim_sample   [MAX_CYC];
    bit      stim_valid    [MAX_CYC];
    bit      exp_hit       [MAX_CYC];
    bit      exp_sss_valid [MAX_CYC];
    bit      exp_nid_valid [MAX_CYC];
    int      n_cyc;
    int      cyc;

    int pss_end  [BURSTS];
    int hit_cyc  [BURSTS];
    int done_cyc [BURSTS];
    int m_nid2   [BURSTS];
    int m_nid1   [BURSTS];
    int m_nid    [BURSTS];

    cell_search dut0 (
        .clk_i          (clk),
        .reset_i        (reset),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .pss_hit_o      (pss_hit),
        .n_id_2_o       (n_id_2),
        .sss_valid_o    (sss_valid),
        .n_id_1_o       (n_id_1),
        .n_id_o         (n_id),
        .n_id_valid_o   (n_id_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            fail_run("wrong value on a DUT output");
        end
    endtask

    function automatic int noise();
        return int'($urandom_range(15)) - 8;
    endfunction

    task automatic push_idle(input int value);
        stim_sample[n_cyc] = sample_t'(value);
        stim_valid[n_cyc]  = 1'b0;
        n_cyc++;
    endtask

    // Valid drops before a sample carry garbage that must be ignored
    task automatic push_sample(input int value);
        while ($urandom_range(3) == 0) begin
            push_idle(int'($urandom_range(255)));
        end
        stim_sample[n_cyc] = sample_t'(value);
        stim_valid[n_cyc]  = 1'b1;
        n_cyc++;
    endtask

    task automatic build_stimulus();
        int nid1;
        int nid2;
        n_cyc = 0;
        repeat (RESET_CYC + QUIET_CYC) begin
            push_idle(0);
        end
        for (int b = 0; b < BURSTS; b++) begin
            nid2 = int'($urandom_range(2));
            nid1 = int'($urandom_range(N_ID1_COUNT - 1));
            repeat (8 + $urandom_range(16)) begin
                push_sample(noise());
            end
            for (int n = 0; n < PSS_LEN; n++) begin
                push_sample(40 * pss_chip(nid2, n) + noise());
            end
            pss_end[b] = n_cyc - 1;
            repeat (GAP_LEN) begin
                push_sample(noise());
            end
            for (int n = 0; n < SSS_LEN; n++) begin
                push_sample(20 * sss_chip(nid1, n, nid2) + noise());
            end
            repeat (10 + $urandom_range(10)) begin
                push_sample(noise());
            end
        end
        repeat (10) begin
            push_idle(0);
        end
    endtask

    // Mode 0 searches, 1 skips the gap, 2 accumulates the SSS
    task automatic run_model();
        int win  [PSS_LEN];
        int vals [N_ID1_COUNT];
        int acc  [N_ID1_COUNT];
        int mode;
        int fill;
        int cnt;
        int b;
        int x;
        mode = 0;
        fill = 0;
        cnt  = 0;
        b    = 0;
        for (int k = 0; k < n_cyc; k++) begin
            if (!stim_valid[k]) continue;
            x = int'(stim_sample[k]);
            if (mode == 0) begin
                for (int n = 0; n < PSS_LEN - 1; n++) begin
                    win[n] = win[n + 1];
                end
                win[PSS_LEN - 1] = x;
                fill++;
                vals = '{default: 0};
                for (int s = 0; s < 3; s++) begin
                    vals[s] = pss_corr(s, win);
                end
                if (fill >= PSS_LEN && vals[arg_max(vals, 3)] >= PSS_THRESHOLD) begin
                    // Noise or a partial PSS crossing the threshold lands here
                    if (b >= BURSTS || k != pss_end[b]) begin
                        fail_run($sformatf("model sees a PSS at cycle %0d off a burst end", k));
                    end
                    m_nid2[b] = arg_max(vals, 3);
                    hit_cyc[b] = k + 1;
                    exp_hit[k + 1] = 1'b1;
                    mode = 1;
                    cnt = 0;
                end
            end else if (mode == 1) begin
                cnt++;
                if (cnt == GAP_LEN) begin
                    mode = 2;
                    cnt = 0;
                    acc = '{default: 0};
                end
            end else begin
                exp_sss_valid[k + 1] = 1'b1;
                for (int c = 0; c < N_ID1_COUNT; c++) begin
                    acc[c] += x * sss_chip(c, cnt, m_nid2[b]);
                end
                cnt++;
                if (cnt == SSS_LEN) begin
                    m_nid1[b] = arg_max(acc, N_ID1_COUNT);
                    m_nid[b] = 3 * m_nid1[b] + m_nid2[b];
                    done_cyc[b] = k + 3;
                    exp_nid_valid[k + 3] = 1'b1;
                    b++;
                    mode = 0;
                    fill = 0;
                end
            end
        end
        if (b != BURSTS) begin
            fail_run("model decoded fewer bursts than were sent");
        end
    endtask

    task automatic drive_and_compare();
        for (int k = 1; k < n_cyc; k++) begin
            @(posedge clk);
            #2;
            check_value("pss_hit_o", pss_hit, exp_hit[k]);
            check_value("sss_valid_o", sss_valid, exp_sss_valid[k]);
            check_value("n_id_valid_o", n_id_valid, exp_nid_valid[k]);
            reset        = (k < RESET_CYC);
            sample       = stim_sample[k];
            sample_valid = stim_valid[k];
        end
    endtask

    task automatic wait_pulse(input bit on_done, input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("%s did not pulse within %0d cycles", what, TIMEOUT));
            end
        end while (!(on_done ? n_id_valid : pss_hit));
    endtask

    task automatic check_events();
        for (int b = 0; b < BURSTS; b++) begin
            wait_pulse(1'b0, "pss_hit_o");
            check_value("pss_hit_o cycle", cyc, hit_cyc[b]);
            check_value("n_id_2_o", n_id_2, m_nid2[b]);
            wait_pulse(1'b1, "n_id_valid_o");
            check_value("n_id_valid_o cycle", cyc, done_cyc[b]);
            check_value("n_id_1_o", n_id_1, m_nid1[b]);
            check_value("n_id_o", n_id, m_nid[b]);
        end
    endtask

    initial begin
        reset        = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        cyc          = 0;
        void'($urandom(18));
        build_stimulus();
        run_model();
        fork
            drive_and_compare();
            check_events();
        join
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb.f
+incdir+bench
rtl/cell_search_pkg.sv
rtl/pss_correlator.sv
rtl/frame_sync.sv
rtl/sss_detector.sv
rtl/cell_search.sv
bench/tb_cell_search.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_cell_search -f tb.f -o sim_cell_search \
    && ./obj_dir/sim_cell_search | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
